// ==== hdl/alu.sv ====
`include "core_defines.svh"

module alu (
  input  core_pkg::alu_op_e op,
  input  logic [`XLEN-1:0]  a,
  input  logic [`XLEN-1:0]  b,
  output logic [`XLEN-1:0]  result
);
  import core_pkg::*;

  logic [$clog2(`XLEN)-1:0] shamt;
  logic                     lt_signed;
  logic                     lt_unsigned;

  // shifts only look at the low bits of b
  assign shamt = b[$clog2(`XLEN)-1:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {{(`XLEN-1){1'b0}}, lt_signed};
      alu_sltu:   result = {{(`XLEN-1){1'b0}}, lt_unsigned};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      // keeps the sign bit of a
      alu_sra:    result = $signed(a) >>> shamt;
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

endmodule

// ==== hdl/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data path and address width of the RV32 core
`define XLEN 32

// architectural integer registers, x0 included
`define NUM_REGS 32

// bits needed to index one register
`define REG_ADDR_W 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// the register file relies on this relation
// NUM_REGS == 2 ** REG_ADDR_W

// pc always advances in whole words
// instructions are 32 bits wide and aligned

`endif

// ==== hdl/core_pkg.sv ====
package core_pkg;

  // operations the ALU can perform
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // lui just forwards the immediate
    alu_pass_b
  } alu_op_e;

  // first ALU operand source, pc is used by auipc
  typedef enum logic {
    a_sel_reg,
    a_sel_pc
  } op_a_sel_e;

  // second ALU operand source
  typedef enum logic {
    b_sel_reg,
    b_sel_imm
  } op_b_sel_e;

endpackage

// ==== hdl/instr_decoder.sv ====
`include "core_defines.svh"

module instr_decoder (
  input  rv_isa_pkg::insn_t      insn,
  output logic [`REG_ADDR_W-1:0] rs1_addr,
  output logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`REG_ADDR_W-1:0] rd_addr,
  output logic                   reg_write,
  output core_pkg::alu_op_e      alu_op,
  output core_pkg::op_a_sel_e    a_sel,
  output core_pkg::op_b_sel_e    b_sel,
  output logic [`XLEN-1:0]       imm,
  output logic                   is_branch,
  output logic [2:0]             branch_funct3,
  output logic                   halt
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;

  // funct3 to ALU op, alt picks sub or sra
  function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      f3_add_sub: funct_to_alu = alt ? alu_sub : alu_add;
      f3_sll:     funct_to_alu = alu_sll;
      f3_slt:     funct_to_alu = alu_slt;
      f3_sltu:    funct_to_alu = alu_sltu;
      f3_xor:     funct_to_alu = alu_xor;
      f3_srl_sra: funct_to_alu = alt ? alu_sra : alu_srl;
      f3_or:      funct_to_alu = alu_or;
      f3_and:     funct_to_alu = alu_and;
    endcase
  endfunction

  // register fields sit at the same bits in every format
  assign rs1_addr      = insn.r.rs1;
  assign rs2_addr      = insn.r.rs2;
  assign rd_addr       = insn.r.rd;
  assign branch_funct3 = insn.b.funct3;

  // sign-extended immediates
  assign imm_i = {{(`XLEN-12){insn.i.imm_11_0[11]}}, insn.i.imm_11_0};
  assign imm_b = {{(`XLEN-13){insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
  assign imm_u = {insn.u.imm_31_12, 12'h000};

  always_comb begin
    reg_write = 1'b0;
    alu_op    = alu_add;
    a_sel     = a_sel_reg;
    b_sel     = b_sel_reg;
    imm       = imm_i;
    is_branch = 1'b0;
    halt      = 1'b0;

    case (insn.r.opcode)
      op_lui: begin
        reg_write = 1'b1;
        alu_op    = alu_pass_b;
        b_sel     = b_sel_imm;
        imm       = imm_u;
      end
      op_auipc: begin
        reg_write = 1'b1;
        a_sel     = a_sel_pc;
        b_sel     = b_sel_imm;
        imm       = imm_u;
      end
      op_branch: begin
        imm       = imm_b;
        // funct3 010 and 011 are not branches
        is_branch = insn.b.funct3[2:1] != 2'b01;
      end
      op_imm: begin
        b_sel  = b_sel_imm;
        alu_op = funct_to_alu(insn.i.funct3,
                              insn.i.funct3 == f3_srl_sra && insn.r.funct7 == f7_alt);
        // upper immediate bits of the shifts act as funct7
        case (insn.i.funct3)
          f3_sll:     reg_write = insn.r.funct7 == f7_base;
          f3_srl_sra: reg_write = insn.r.funct7 == f7_base || insn.r.funct7 == f7_alt;
          default:    reg_write = 1'b1;
        endcase
      end
      op_reg: begin
        alu_op    = funct_to_alu(insn.r.funct3, insn.r.funct7 == f7_alt);
        reg_write = insn.r.funct7 == f7_base ||
                    (insn.r.funct7 == f7_alt &&
                     (insn.r.funct3 == f3_add_sub || insn.r.funct3 == f3_srl_sra));
      end
      op_system: begin
        halt = insn == ecall_word;
      end
      default: begin
        // anything else falls through as a no-op
      end
    endcase
  end

endmodule

// ==== hdl/pc_unit.sv ====
`include "core_defines.svh"

module pc_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  input  logic [`XLEN-1:0] imm,
  input  logic             is_branch,
  input  logic             halt,
  input  logic [2:0]       branch_funct3,
  output logic [`XLEN-1:0] pc
);

  logic             eq;
  logic             lt;
  logic             ltu;
  logic             cond;
  logic             taken;
  logic [`XLEN-1:0] pc_next;

  assign eq  = rs1_data == rs2_data;
  assign lt  = $signed(rs1_data) < $signed(rs2_data);
  assign ltu = rs1_data < rs2_data;

  // funct3 bit 2 picks a compare over equality, bit 1 unsigned,
  // bit 0 inverts the outcome (bne, bge, bgeu)
  assign cond  = branch_funct3[2] ? (branch_funct3[1] ? ltu : lt) : eq;
  assign taken = is_branch && (cond ^ branch_funct3[0]);

  always_comb begin
    if (halt) begin
      // stay on the ecall
      pc_next = pc;
    end else if (taken) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc + 4;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// ==== hdl/reg_file.sv ====
`include "core_defines.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic [`REG_ADDR_W-1:0] rd_addr,
  input  logic                   we,
  input  logic [`XLEN-1:0]       rd_data,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin
      // writes to x0 are dropped
      regs[rd_addr] <= rd_data;
    end
  end

  // combinational reads, x0 always zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hdl/rv_core.sv ====
`include "core_defines.svh"

module rv_core (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_isa_pkg::insn_t      insn,
  output logic [`XLEN-1:0]       pc,
  output logic                   halt,
  output logic                   wb_valid,
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data
);
  import core_pkg::*;

  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`REG_ADDR_W-1:0] rd_addr;
  logic                   reg_write;
  alu_op_e                alu_op;
  op_a_sel_e              a_sel;
  op_b_sel_e              b_sel;
  logic [`XLEN-1:0]       imm;
  logic                   is_branch;
  logic [2:0]             branch_funct3;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic [`XLEN-1:0]       alu_a;
  logic [`XLEN-1:0]       alu_b;
  logic [`XLEN-1:0]       alu_result;

  instr_decoder u_dec (
    .insn          (insn),
    .rs1_addr      (rs1_addr),
    .rs2_addr      (rs2_addr),
    .rd_addr       (rd_addr),
    .reg_write     (reg_write),
    .alu_op        (alu_op),
    .a_sel         (a_sel),
    .b_sel         (b_sel),
    .imm           (imm),
    .is_branch     (is_branch),
    .branch_funct3 (branch_funct3),
    .halt          (halt)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .we       (reg_write),
    .rd_data  (alu_result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // operand muxes, pc for auipc and the immediate for I and U forms
  assign alu_a = (a_sel == a_sel_pc) ? pc : rs1_data;
  assign alu_b = (b_sel == b_sel_imm) ? imm : rs2_data;

  alu u_alu (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  pc_unit u_pc (
    .clk           (clk),
    .rst           (rst),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .imm           (imm),
    .is_branch     (is_branch),
    .halt          (halt),
    .branch_funct3 (branch_funct3),
    .pc            (pc)
  );

  // trace shows the register file write as issued, x0 included
  assign wb_valid = reg_write;
  assign wb_rd    = rd_addr;
  assign wb_data  = alu_result;

endmodule

// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_branch = 7'b1100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  // funct3 of the ALU instructions, shared by the imm and reg forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 of the conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // funct7, alt selects sub and the arithmetic shift
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  // ecall has every field besides the opcode at zero
  localparam logic [31:0] ecall_word = 32'h0000_0073;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  // branch offset bits are scattered around the register fields
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  // one instruction word, seen through each format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    u_fmt_t u;
  } insn_t;

endpackage

// ==== sources.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/rv_core.sv
testbench/tb_rv_core.sv

// ==== testbench/tb_rv_core.sv ====
`include "core_defines.svh"

module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_isa_pkg::*;

  localparam int num_progs  = 8;
  localparam int prog_len   = 48;
  localparam int max_cycles = num_progs * (prog_len + 1 + 3) + 100;

  logic                   clk;
  logic                   rst;
  insn_t                  insn;
  logic [`XLEN-1:0]       pc;
  logic                   halt;
  logic                   wb_valid;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_data;

  logic [31:0]      prog [prog_len];
  logic [`XLEN-1:0] mregs [`NUM_REGS];
  logic [`XLEN-1:0] mpc;
  logic [31:0]      rng_state;
  int               errors = 0;
  int               checks = 0;
  int               cycles = 0;

  rv_core uut (
    .clk      (clk),
    .rst      (rst),
    .insn     (insn),
    .pc       (pc),
    .halt     (halt),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Errors found");
      $finish;
    end
  end

  function automatic logic [31:0] rand_word();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    rand_word = x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // one random instruction for word idx
  // branch targets stay inside the program
  function automatic logic [31:0] make_insn(input int idx);
    insn_t       w;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [6:0]  f7;
    logic [12:0] off;
    w  = '0;
    r1 = rand_word();
    r2 = rand_word();
    f7 = (r2[14:12] == 3'd5 && r2[30]) ? f7_alt : f7_base;
    if (r1[3:0] == 4'd0 || r1[3:0] == 4'd1) begin
      w.u.imm_31_12 = r2[31:12];
      w.u.rd        = r2[4:0];
      w.u.opcode    = r1[0] ? op_auipc : op_lui;
    end else if (r1[3:0] < 4'd7) begin
      w.i.rd     = r2[4:0];
      w.i.rs1    = r2[9:5];
      w.i.funct3 = r2[14:12];
      w.i.opcode = op_imm;
      if (r2[13:12] == 2'b01) begin
        // shift amount sits in the low imm bits with funct7 above it
        w.i.imm_11_0 = {f7, r2[19:15]};
      end else begin
        w.i.imm_11_0 = r2[31:20];
      end
    end else if (r1[3:0] < 4'd12) begin
      w.r.rd     = r2[4:0];
      w.r.rs1    = r2[9:5];
      w.r.rs2    = r2[19:15];
      w.r.funct3 = r2[14:12];
      w.r.funct7 = (r2[14:12] == 3'b000 && r2[30]) ? f7_alt : f7;
      w.r.opcode = op_reg;
    end else if (r1[3:0] < 4'd15) begin
      off = 13'(4 * (1 + int'(r1[23:8]) % (prog_len - 1 - idx)));
      w.b.imm_12   = off[12];
      w.b.imm_11   = off[11];
      w.b.imm_10_5 = off[10:5];
      w.b.imm_4_1  = off[4:1];
      w.b.rs1      = r2[9:5];
      w.b.rs2      = r2[19:15];
      // 010 and 011 are not branches so they fold onto blt and bge
      w.b.funct3   = (r2[14:13] == 2'b01) ? (r2[14:12] ^ 3'b110) : r2[14:12];
      w.b.opcode   = op_branch;
    end else begin
      // fence is not implemented by the core
      w = 32'h0000_000f;
    end
    make_insn = w;
  endfunction

  function automatic logic [31:0] fetch(input logic [`XLEN-1:0] addr);
    logic [`XLEN-1:0] ofs;
    ofs = addr - `RESET_PC;
    if (ofs[1:0] != 2'b00 || ofs >= 4 * prog_len) begin
      fetch = ecall_word;
    end else begin
      fetch = prog[ofs >> 2];
    end
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: alu_ref = alt ? a - b : a + b;
      3'd1: alu_ref = a << b[4:0];
      3'd2: alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: alu_ref = (a < b) ? 32'd1 : 32'd0;
      3'd4: alu_ref = a ^ b;
      3'd5: begin
        if (alt) begin
          alu_ref = $signed(a) >>> b[4:0];
        end else begin
          alu_ref = a >> b[4:0];
        end
      end
      3'd6: alu_ref = a | b;
      default: alu_ref = a & b;
    endcase
  endfunction

  // ISA model of one instruction at mpc
  task automatic model_step(input logic [31:0] w, output logic valid, output logic [4:0] rd,
                            output logic [31:0] data, output logic hlt,
                            output logic [31:0] npc);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic        take;
    a     = mregs[w[19:15]];
    b     = mregs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    valid = 1'b0;
    rd    = w[11:7];
    data  = '0;
    hlt   = 1'b0;
    take  = 1'b0;
    npc   = mpc + 4;
    case (w[6:0])
      op_lui: begin
        valid = 1'b1;
        data  = {w[31:12], 12'h000};
      end
      op_auipc: begin
        valid = 1'b1;
        data  = mpc + {w[31:12], 12'h000};
      end
      op_imm: begin
        valid = 1'b1;
        data  = alu_ref(w[14:12], w[14:12] == 3'd5 && w[30], a, imm_i);
      end
      op_reg: begin
        valid = 1'b1;
        data  = alu_ref(w[14:12], w[30], a, b);
      end
      op_branch: begin
        case (w[14:12])
          3'd0: take = a == b;
          3'd1: take = a != b;
          3'd4: take = $signed(a) < $signed(b);
          3'd5: take = $signed(a) >= $signed(b);
          3'd6: take = a < b;
          3'd7: take = a >= b;
          default: take = 1'b0;
        endcase
        if (take) begin
          npc = mpc + imm_b;
        end
      end
      op_system: begin
        if (w == 32'h0000_0073) begin
          hlt = 1'b1;
          npc = mpc;
        end
      end
      default: begin
      end
    endcase
  endtask

  task automatic run_program(input int p);
    logic        exp_valid;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        exp_halt;
    logic [31:0] exp_npc;
    int          steps;
    logic        done;
    string       tag;
    for (int i = 0; i < prog_len - 1; i++) begin
      prog[i] = make_insn(i);
    end
    prog[prog_len-1] = ecall_word;
    @(posedge clk);
    #1;
    rst  = 1'b1;
    insn = ecall_word;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < `NUM_REGS; i++) begin
      mregs[i] = '0;
    end
    mpc   = `RESET_PC;
    steps = 0;
    done  = 1'b0;
    while (!done) begin
      tag = $sformatf("prog %0d step %0d", p, steps);
      check_value({tag, " pc"}, mpc, pc);
      insn = fetch(pc);
      @(negedge clk);
      model_step(insn, exp_valid, exp_rd, exp_data, exp_halt, exp_npc);
      check_value({tag, " wb_valid"}, 32'(exp_valid), 32'(wb_valid));
      check_value({tag, " halt"}, 32'(exp_halt), 32'(halt));
      if (exp_valid) begin
        check_value({tag, " wb_rd"}, 32'(exp_rd), 32'(wb_rd));
        check_value({tag, " wb_data"}, exp_data, wb_data);
        if (exp_rd != 5'd0) begin
          mregs[exp_rd] = exp_data;
        end
      end
      mpc = exp_npc;
      @(posedge clk);
      #1;
      steps++;
      if (exp_halt) begin
        // pc must stay on the ecall
        check_value({tag, " halted pc"}, mpc, pc);
        done = 1'b1;
      end else if (steps > prog_len) begin
        errors++;
        $display("program %0d did not reach ecall within %0d instructions", p, prog_len);
        done = 1'b1;
      end
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    insn      = ecall_word;
    rng_state = 32'hc8488995;
    for (int p = 0; p < num_progs; p++) begin
      run_program(p);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
